// ==== remap_pkg.sv ====
/*
  Widths and ID types shared by the read-path ID remapper.
  NUM_OUT_IDS is derived from OUT_ID_W, so every downstream ID owns one table slot.
  Lengths count beats minus one, as on AXI AR.
*/
package remap_pkg;

  // Upstream and downstream ID widths
  localparam int unsigned IN_ID_W = 4;
  localparam int unsigned OUT_ID_W = 2;

  // One table slot per downstream ID
  localparam int unsigned NUM_OUT_IDS = 1 << OUT_ID_W;

  // Payload widths
  localparam int unsigned ADDR_W = 16;
  localparam int unsigned DATA_W = 16;

  // Burst length field, beats minus one
  localparam int unsigned LEN_W = 4;

  typedef logic [IN_ID_W-1:0] in_id_t;
  typedef logic [OUT_ID_W-1:0] out_id_t;
  typedef logic [LEN_W-1:0] len_t;

endpackage

// ==== remap_table.sv ====
/*
  Slot table from downstream ID to upstream ID.
  One burst per slot; the lowest free slot is always offered next.
  Allocation wins over a release that addresses the same slot.
*/
module remap_table (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                alloc_i,
  input  remap_pkg::in_id_t                   alloc_in_id_i,
  output logic                                has_free_o,
  output remap_pkg::out_id_t                  free_id_o,
  input  remap_pkg::out_id_t                  lookup_id_i,
  output remap_pkg::in_id_t                   lookup_in_id_o,
  input  logic                                release_i,
  output logic [remap_pkg::NUM_OUT_IDS-1:0]   busy_o
);

  import remap_pkg::*;

  // Upstream ID stored per slot
  in_id_t in_id_mem [NUM_OUT_IDS];

  logic [NUM_OUT_IDS-1:0] busy_q;
  out_id_t                free_id;
  logic                   has_free;

  // Lowest free slot, scanned from the top so the lowest index wins
  always_comb begin
    free_id  = '0;
    has_free = 1'b0;
    for (int i = NUM_OUT_IDS - 1; i >= 0; i--) begin
      if (!busy_q[i]) begin
        free_id  = out_id_t'(i);
        has_free = 1'b1;
      end
    end
  end

  // Busy flags
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= '0;
    end else begin
      if (release_i) begin
        busy_q[lookup_id_i] <= 1'b0;
      end
      // Alloc only ever targets a free slot
      if (alloc_i && has_free) begin
        busy_q[free_id] <= 1'b1;
      end
    end
  end

  // Mapping memory, written on allocation
  always_ff @(posedge clk_i) begin
    if (alloc_i && has_free) begin
      in_id_mem[free_id] <= alloc_in_id_i;
    end
  end

  assign has_free_o     = has_free;
  assign free_id_o      = free_id;
  assign lookup_in_id_o = in_id_mem[lookup_id_i];
  assign busy_o         = busy_q;

endmodule

// ==== remap_ctrl.sv ====
/*
  AR path controller with two states, IDLE and ISSUE.
  Accepts at most one upstream AR every 2 cycles; downstream valid follows the
  upstream transfer by exactly 1 cycle and holds until m_ar_ready_i.
*/
module remap_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      s_ar_valid_i,
  input  remap_pkg::in_id_t         s_ar_id_i,
  input  logic [remap_pkg::ADDR_W-1:0] s_ar_addr_i,
  input  remap_pkg::len_t           s_ar_len_i,
  output logic                      s_ar_ready_o,
  input  logic                      has_free_i,
  input  remap_pkg::out_id_t        free_id_i,
  output logic                      alloc_o,
  output remap_pkg::in_id_t         alloc_in_id_o,
  output logic                      m_ar_valid_o,
  output remap_pkg::out_id_t        m_ar_id_o,
  output logic [remap_pkg::ADDR_W-1:0] m_ar_addr_o,
  output remap_pkg::len_t           m_ar_len_o,
  input  logic                      m_ar_ready_i,
  output logic                      ar_issue_o,
  output logic                      ctrl_idle_o
);

  import remap_pkg::*;

  typedef enum logic {
    IDLE,
    ISSUE
  } state_e;

  state_e state_q;
  state_e state_d;

  // Captured request
  logic [ADDR_W-1:0] addr_q;
  len_t              len_q;
  out_id_t           slot_q;

  // Accept only while idle and a slot is free
  assign s_ar_ready_o  = (state_q == IDLE) && has_free_i;
  assign alloc_o       = s_ar_valid_i && s_ar_ready_o;
  assign alloc_in_id_o = s_ar_id_i;

  assign m_ar_valid_o = (state_q == ISSUE);
  assign ar_issue_o   = m_ar_valid_o && m_ar_ready_i;
  assign ctrl_idle_o  = (state_q == IDLE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (alloc_o) state_d = ISSUE;
      ISSUE:   if (m_ar_ready_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (alloc_o) begin
      addr_q <= s_ar_addr_i;
      len_q  <= s_ar_len_i;
      slot_q <= free_id_i;
    end
  end

  assign m_ar_id_o   = slot_q;
  assign m_ar_addr_o = addr_q;
  assign m_ar_len_o  = len_q;

endmodule

// ==== beat_counter.sv ====
/*
  Beats remaining per downstream ID.
  Loaded with the AR length on issue, counted down per R beat.
  A counter at zero means the next beat on that ID must be the last one.
*/
module beat_counter (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               load_i,
  input  remap_pkg::out_id_t load_id_i,
  input  remap_pkg::len_t    load_len_i,
  input  logic               beat_i,
  input  remap_pkg::out_id_t beat_id_i,
  output logic               expect_last_o
);

  import remap_pkg::*;

  len_t remain_q [NUM_OUT_IDS];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_OUT_IDS; i++) begin
        remain_q[i] <= '0;
      end
    end else begin
      // Saturate at zero, a stray beat must not wrap the count
      if (beat_i && (remain_q[beat_id_i] != '0)) begin
        remain_q[beat_id_i] <= remain_q[beat_id_i] - 1'b1;
      end
      // A fresh burst overrides any count left on its slot
      if (load_i) begin
        remain_q[load_id_i] <= load_len_i;
      end
    end
  end

  assign expect_last_o = (remain_q[beat_id_i] == '0);

endmodule

// ==== remap_compare.sv ====
/*
  Synthesizable transaction checker on the downstream R channel.
  err_o is sticky until reset and rises one cycle after the offending beat.
  idle_o only reflects table occupancy and the AR controller, not R backlog
  in the downstream slave.
*/
module remap_compare (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              beat_i,
  input  logic                              last_i,
  input  remap_pkg::out_id_t                beat_id_i,
  input  logic [remap_pkg::NUM_OUT_IDS-1:0] busy_i,
  input  logic                              expect_last_i,
  input  logic                              ctrl_idle_i,
  output logic                              err_o,
  output logic                              idle_o
);

  import remap_pkg::*;

  logic orphan_beat;
  logic last_mismatch;
  logic err_q;

  // Beat on an ID with no burst in flight
  assign orphan_beat = beat_i && !busy_i[beat_id_i];

  // Last flag disagrees with the remaining beat count
  assign last_mismatch = beat_i && (last_i != expect_last_i);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      err_q <= 1'b0;
    end else if (orphan_beat || last_mismatch) begin
      err_q <= 1'b1;
    end
  end

  assign err_o = err_q;

  // Nothing outstanding and no AR waiting to issue
  assign idle_o = ~|busy_i && ctrl_idle_i;

endmodule

// ==== id_remap_top.sv ====
/*
  Read-path AXI ID remapper with built-in checker.
  4-bit upstream IDs are mapped onto four 2-bit downstream IDs, one burst each.
  R is combinational; s_r_ready_i back-pressures the downstream side directly.
  Write channels are not supported.
*/
module id_remap_top (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  // Upstream AR
  input  logic                              s_ar_valid_i,
  input  remap_pkg::in_id_t                 s_ar_id_i,
  input  logic [remap_pkg::ADDR_W-1:0]      s_ar_addr_i,
  input  remap_pkg::len_t                   s_ar_len_i,
  output logic                              s_ar_ready_o,
  // Upstream R
  output logic                              s_r_valid_o,
  output remap_pkg::in_id_t                 s_r_id_o,
  output logic [remap_pkg::DATA_W-1:0]      s_r_data_o,
  output logic                              s_r_last_o,
  input  logic                              s_r_ready_i,
  // Downstream AR
  output logic                              m_ar_valid_o,
  output remap_pkg::out_id_t                m_ar_id_o,
  output logic [remap_pkg::ADDR_W-1:0]      m_ar_addr_o,
  output remap_pkg::len_t                   m_ar_len_o,
  input  logic                              m_ar_ready_i,
  // Downstream R
  input  logic                              m_r_valid_i,
  input  remap_pkg::out_id_t                m_r_id_i,
  input  logic [remap_pkg::DATA_W-1:0]      m_r_data_i,
  input  logic                              m_r_last_i,
  output logic                              m_r_ready_o,
  // Status
  output logic                              err_o,
  output logic                              idle_o
);

  import remap_pkg::*;

  logic                   has_free;
  out_id_t                free_id;
  logic                   alloc;
  in_id_t                 alloc_in_id;
  logic                   ar_issue;
  logic                   ctrl_idle;
  logic [NUM_OUT_IDS-1:0] busy;
  logic                   expect_last;
  logic                   r_xfer;
  logic                   r_last_xfer;

  // R transfer and end of burst
  assign r_xfer      = m_r_valid_i && s_r_ready_i;
  assign r_last_xfer = r_xfer && m_r_last_i;

  // Zero-latency R path
  assign s_r_valid_o = m_r_valid_i;
  assign s_r_data_o  = m_r_data_i;
  assign s_r_last_o  = m_r_last_i;
  assign m_r_ready_o = s_r_ready_i;

  remap_ctrl remap_ctrl_inst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .s_ar_valid_i (s_ar_valid_i),
    .s_ar_id_i    (s_ar_id_i),
    .s_ar_addr_i  (s_ar_addr_i),
    .s_ar_len_i   (s_ar_len_i),
    .s_ar_ready_o (s_ar_ready_o),
    .has_free_i   (has_free),
    .free_id_i    (free_id),
    .alloc_o      (alloc),
    .alloc_in_id_o(alloc_in_id),
    .m_ar_valid_o (m_ar_valid_o),
    .m_ar_id_o    (m_ar_id_o),
    .m_ar_addr_o  (m_ar_addr_o),
    .m_ar_len_o   (m_ar_len_o),
    .m_ar_ready_i (m_ar_ready_i),
    .ar_issue_o   (ar_issue),
    .ctrl_idle_o  (ctrl_idle)
  );

  remap_table remap_table_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .alloc_i       (alloc),
    .alloc_in_id_i (alloc_in_id),
    .has_free_o    (has_free),
    .free_id_o     (free_id),
    .lookup_id_i   (m_r_id_i),
    .lookup_in_id_o(s_r_id_o),
    .release_i     (r_last_xfer),
    .busy_o        (busy)
  );

  beat_counter beat_counter_inst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .load_i       (ar_issue),
    .load_id_i    (m_ar_id_o),
    .load_len_i   (m_ar_len_o),
    .beat_i       (r_xfer),
    .beat_id_i    (m_r_id_i),
    .expect_last_o(expect_last)
  );

  remap_compare remap_compare_inst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .beat_i       (r_xfer),
    .last_i       (r_last_xfer),
    .beat_id_i    (m_r_id_i),
    .busy_i       (busy),
    .expect_last_i(expect_last),
    .ctrl_idle_i  (ctrl_idle),
    .err_o        (err_o),
    .idle_o       (idle_o)
  );

endmodule

// ==== id_remap_properties.sv ====
/*
  AR handshake and occupancy rules on remap_ctrl, attached with bind.
  Checks are off while rst_n_i is low.
*/
module id_remap_properties (
  input logic                         clk_i,
  input logic                         rst_n_i,
  input logic                         s_ar_valid_i,
  input logic                         s_ar_ready_i,
  input logic                         has_free_i,
  input logic                         m_ar_valid_i,
  input logic                         m_ar_ready_i,
  input remap_pkg::out_id_t           m_ar_id_i,
  input logic [remap_pkg::ADDR_W-1:0] m_ar_addr_i,
  input remap_pkg::len_t              m_ar_len_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // Downstream AR holds with a stable payload until accepted
  ar_valid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    m_ar_valid_i && !m_ar_ready_i |=> m_ar_valid_i)
    else $error("m_ar_valid dropped before m_ar_ready");

  ar_payload_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    m_ar_valid_i && !m_ar_ready_i |=>
      $stable(m_ar_id_i) && $stable(m_ar_addr_i) && $stable(m_ar_len_i))
    else $error("downstream AR payload changed while waiting for ready");

  // Upstream accept turns into downstream valid one cycle later, with no second accept
  ar_accept_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    s_ar_valid_i && s_ar_ready_i |=> m_ar_valid_i && !s_ar_ready_i)
    else $error("upstream accept not followed by downstream AR in the next cycle");

  // A request waiting on a full table must not reach the downstream side
  ar_full_blocks_issue: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    s_ar_valid_i && !has_free_i && !m_ar_valid_i |=> !m_ar_valid_i)
    else $error("downstream AR issued while the table was full");

endmodule

bind remap_ctrl id_remap_properties id_remap_properties_inst (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .s_ar_valid_i(s_ar_valid_i),
  .s_ar_ready_i(s_ar_ready_o),
  .has_free_i  (has_free_i),
  .m_ar_valid_i(m_ar_valid_o),
  .m_ar_ready_i(m_ar_ready_i),
  .m_ar_id_i   (m_ar_id_o),
  .m_ar_addr_i (m_ar_addr_o),
  .m_ar_len_i  (m_ar_len_o)
);

// ==== tb_id_remap.sv ====
/*
  Testbench for id_remap_top. A downstream slave model answers the pending
  bursts in reverse order of issue, and beat k of a burst carries its address plus k.
  Both ready inputs are randomized from a fixed xorshift seed.
*/
module tb_id_remap;
  timeunit 1ns;
  timeprecision 1ps;

  import remap_pkg::*;

  localparam int TIMEOUT    = 64;
  localparam int NUM_BURSTS = 8;

  logic              clk_i, rst_n_i;
  logic              s_ar_valid_i, s_ar_ready_o;
  in_id_t            s_ar_id_i, s_r_id_o;
  logic [ADDR_W-1:0] s_ar_addr_i, m_ar_addr_o;
  len_t              s_ar_len_i, m_ar_len_o;
  logic              s_r_valid_o, s_r_last_o, s_r_ready_i;
  logic [DATA_W-1:0] s_r_data_o, m_r_data_i;
  logic              m_ar_valid_o, m_ar_ready_i;
  out_id_t           m_ar_id_o, m_r_id_i;
  logic              m_r_valid_i, m_r_last_i, m_r_ready_o;
  logic              err_o, idle_o;

  // Upstream ID, address, length and the downstream slot each burst must land on
  in_id_t            tbl_id   [NUM_BURSTS] = '{4'h9, 4'h2, 4'hf, 4'h5, 4'ha, 4'h0, 4'h7, 4'hc};
  logic [ADDR_W-1:0] tbl_addr [NUM_BURSTS] = '{16'h1000, 16'h2040, 16'h30f0, 16'h4ff8,
                                              16'h5a00, 16'h6000, 16'h7ffe, 16'hfffc};
  len_t              tbl_len  [NUM_BURSTS] = '{4'd3, 4'd0, 4'd7, 4'd1, 4'd2, 4'd4, 4'd0, 4'd5};
  out_id_t           tbl_slot [NUM_BURSTS] = '{2'd0, 2'd1, 2'd2, 2'd3, 2'd3, 2'd0, 2'd1, 2'd2};

  // Slave model state
  out_id_t     issued_slot [NUM_BURSTS];
  int          pending [$];
  logic [31:0] rng_state;

  string test_name;
  int    error_count;
  int    test_start_errors;
  int    tests_run;
  int    tests_failed;
  logic  timed_out;

  id_remap_top id_remap_top_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // Ready with three chances in four
  function automatic logic next_ready();
    rng_state = xorshift32(rng_state);
    return |rng_state[1:0];
  endfunction

  task automatic report_mismatch(input string what, input string exp, input string act);
    $display("FAILED %s %s: expected %s, actual %s", test_name, what, exp, act);
    error_count++;
  endtask

  task automatic report_timeout(input string what);
    $display("ERROR %s: timed out waiting for %s", test_name, what);
    timed_out = 1'b1;
    error_count++;
  endtask

  task automatic check_id(input string what, input in_id_t exp, input in_id_t act);
    if (act !== exp) report_mismatch(what, $sformatf("%h", exp), $sformatf("%h", act));
  endtask
  task automatic check_slot(input string what, input out_id_t exp, input out_id_t act);
    if (act !== exp) report_mismatch(what, $sformatf("%h", exp), $sformatf("%h", act));
  endtask
  task automatic check_addr(input string what, input logic [ADDR_W-1:0] exp,
                            input logic [ADDR_W-1:0] act);
    if (act !== exp) report_mismatch(what, $sformatf("%h", exp), $sformatf("%h", act));
  endtask
  task automatic check_len(input string what, input len_t exp, input len_t act);
    if (act !== exp) report_mismatch(what, $sformatf("%0d", exp), $sformatf("%0d", act));
  endtask
  task automatic check_data(input string what, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
    if (act !== exp) report_mismatch(what, $sformatf("%h", exp), $sformatf("%h", act));
  endtask
  task automatic check_last(input string what, input logic exp, input logic act);
    if (act !== exp) report_mismatch(what, $sformatf("%b", exp), $sformatf("%b", act));
  endtask
  task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp) report_mismatch(what, $sformatf("%b", exp), $sformatf("%b", act));
  endtask

  task automatic start_test(input string name);
    test_name         = name;
    test_start_errors = error_count;
  endtask

  task automatic end_test();
    tests_run++;
    if (error_count == test_start_errors) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", test_name, error_count - test_start_errors);
    end
  endtask

  task automatic apply_reset();
    rst_n_i = 1'b0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
  endtask

  // Upstream AR, then the slave model takes the downstream AR
  task automatic issue_burst(input int b);
    int   cycles;
    logic done;
    s_ar_valid_i = 1'b1;
    s_ar_id_i    = tbl_id[b];
    s_ar_addr_i  = tbl_addr[b];
    s_ar_len_i   = tbl_len[b];
    cycles = 0;
    done   = 1'b0;
    while (!done && !timed_out) begin
      @(negedge clk_i);
      done = s_ar_ready_o;
      @(posedge clk_i);
      #1;
      cycles++;
      if (!done && cycles >= TIMEOUT) report_timeout("s_ar_ready_o");
    end
    s_ar_valid_i = 1'b0;
    cycles = 0;
    done   = 1'b0;
    while (!done && !timed_out) begin
      m_ar_ready_i = next_ready();
      @(negedge clk_i);
      // Downstream valid follows the upstream transfer by one cycle
      if (cycles == 0) begin
        check_flag("m_ar_valid_o latency", 1'b1, m_ar_valid_o);
        check_flag("s_ar_ready_o in ISSUE", 1'b0, s_ar_ready_o);
      end
      if (m_ar_valid_o && m_ar_ready_i) begin
        done = 1'b1;
        check_slot("m_ar_id_o", tbl_slot[b], m_ar_id_o);
        check_addr("m_ar_addr_o", tbl_addr[b], m_ar_addr_o);
        check_len("m_ar_len_o", tbl_len[b], m_ar_len_o);
        issued_slot[b] = m_ar_id_o;
        pending.push_back(b);
      end
      @(posedge clk_i);
      #1;
      cycles++;
      if (!done && cycles >= TIMEOUT) report_timeout("m_ar_valid_o");
    end
    m_ar_ready_i = 1'b0;
  endtask

  // Slave model answers the most recently issued burst still pending
  task automatic respond_newest();
    int   b;
    int   cycles;
    logic done;
    if (pending.size() == 0) return;
    b = pending.pop_back();
    for (int k = 0; k <= int'(tbl_len[b]); k++) begin
      m_r_valid_i = 1'b1;
      m_r_id_i    = issued_slot[b];
      m_r_data_i  = tbl_addr[b] + DATA_W'(k);
      m_r_last_i  = (k == int'(tbl_len[b]));
      cycles = 0;
      done   = 1'b0;
      while (!done && !timed_out) begin
        s_r_ready_i = next_ready();
        @(negedge clk_i);
        if (s_r_ready_i) begin
          done = 1'b1;
          check_flag("s_r_valid_o", 1'b1, s_r_valid_o);
          check_id("s_r_id_o", tbl_id[b], s_r_id_o);
          check_data("s_r_data_o", tbl_addr[b] + DATA_W'(k), s_r_data_o);
          check_last("s_r_last_o", k == int'(tbl_len[b]), s_r_last_o);
          check_flag("err_o", 1'b0, err_o);
        end
        check_flag("m_r_ready_o", s_r_ready_i, m_r_ready_o);
        @(posedge clk_i);
        #1;
        cycles++;
        if (!done && cycles >= TIMEOUT) report_timeout("upstream R ready");
      end
    end
    m_r_valid_i = 1'b0;
    m_r_last_i  = 1'b0;
    s_r_ready_i = 1'b0;
  endtask

  initial begin
    rst_n_i      = 1'b0;
    s_ar_valid_i = 1'b0;
    s_ar_id_i    = '0;
    s_ar_addr_i  = '0;
    s_ar_len_i   = '0;
    s_r_ready_i  = 1'b0;
    m_ar_ready_i = 1'b0;
    m_r_valid_i  = 1'b0;
    m_r_id_i     = '0;
    m_r_data_i   = '0;
    m_r_last_i   = 1'b0;
    rng_state    = 32'hb132a00d;
    error_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    apply_reset();

    start_test("reset state");
    @(negedge clk_i);
    check_flag("idle_o", 1'b1, idle_o);
    check_flag("err_o", 1'b0, err_o);
    check_flag("m_ar_valid_o", 1'b0, m_ar_valid_o);
    @(posedge clk_i);
    #1;
    end_test();

    // Four bursts in flight and none answered
    start_test("fill table");
    for (int b = 0; b < 4; b++) issue_burst(b);
    // Fifth request stays pending on the full table
    s_ar_valid_i = 1'b1;
    s_ar_id_i    = tbl_id[4];
    s_ar_addr_i  = tbl_addr[4];
    s_ar_len_i   = tbl_len[4];
    repeat (4) begin
      @(negedge clk_i);
      check_flag("s_ar_ready_o when full", 1'b0, s_ar_ready_o);
      check_flag("m_ar_valid_o when full", 1'b0, m_ar_valid_o);
      check_flag("idle_o when busy", 1'b0, idle_o);
      @(posedge clk_i);
      #1;
    end
    end_test();

    // Slot 3 drains first, so the waiting burst 4 must reuse it
    start_test("slot reuse");
    respond_newest();
    issue_burst(4);
    end_test();

    start_test("reverse drain");
    while (pending.size() > 0) respond_newest();
    end_test();

    start_test("second batch");
    for (int b = 5; b < NUM_BURSTS; b++) issue_burst(b);
    while (pending.size() > 0) respond_newest();
    @(negedge clk_i);
    check_flag("idle_o after drain", 1'b1, idle_o);
    check_flag("err_o after legal traffic", 1'b0, err_o);
    @(posedge clk_i);
    #1;
    end_test();

    // Single beat on slot 1 with nothing in flight
    start_test("orphan beat");
    m_r_valid_i = 1'b1;
    m_r_id_i    = 2'd1;
    m_r_data_i  = 16'hdead;
    m_r_last_i  = 1'b1;
    s_r_ready_i = 1'b1;
    @(posedge clk_i);
    #1;
    m_r_valid_i = 1'b0;
    m_r_last_i  = 1'b0;
    s_r_ready_i = 1'b0;
    repeat (4) begin
      @(negedge clk_i);
      check_flag("err_o sticky", 1'b1, err_o);
      @(posedge clk_i);
      #1;
    end
    apply_reset();
    @(negedge clk_i);
    check_flag("err_o after reset", 1'b0, err_o);
    check_flag("idle_o after reset", 1'b1, idle_o);
    end_test();

    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== id_remap.f ====
remap_pkg.sv
remap_table.sv
remap_ctrl.sv
beat_counter.sv
remap_compare.sv
id_remap_top.sv
id_remap_properties.sv
tb_id_remap.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_id_remap -f id_remap.f \
  > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vtb_id_remap > sim.log 2>&1
sim_status=$?
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
[ "$sim_status" -eq 0 ] && grep -q "Simulation passed" sim.log && exit 0
exit 1
